//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

   // 8N1 framing, data width fixed here
   localparam int DATA_BITS = 8;

   typedef logic [DATA_BITS-1:0] byte_t;

   // oversampling tick position within one bit
   typedef logic [3:0] tick_cnt_t;

   // ticks from falling edge to start bit centre
   localparam tick_cnt_t START_TICKS = 4'd7;
   // last tick index of a full 16-tick bit
   localparam tick_cnt_t BIT_TICKS = 4'd15;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   // host receive channel
   typedef enum logic [1:0] {
      CTRL_IDLE,
      CTRL_OFFER,
      CTRL_RELEASE
   } ctrl_state_t;

endpackage

`default_nettype wire

//--- serial_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface serial_byte_if ();

   // controller to transmitter
   uart_pkg::byte_t tx_data;
   logic            tx_start;
   // frame in progress
   logic            tx_busy;

   // receiver to controller
   uart_pkg::byte_t rx_data;
   logic            rx_done;
   logic            rx_frame_err;

   modport ctrl (
      output tx_data,
      output tx_start,
      input  tx_busy,
      input  rx_data,
      input  rx_done,
      input  rx_frame_err
   );

   modport tx (
      input  tx_data,
      input  tx_start,
      output tx_busy
   );

   modport rx (
      output rx_data,
      output rx_done,
      output rx_frame_err
   );

endinterface

`default_nettype wire

//--- baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_gen #(
   parameter int CLKS_PER_TICK = 4
) (
   input  wire  clock,
   input  wire  reset,
   output logic tick
);

   // at least one bit even for a divide by one
   localparam int CNT_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
   localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_TICK - 1);

   logic [CNT_W-1:0] count;

   // free running divider, one-clock tick on wrap
   always_ff @(posedge clock) begin
      if (reset) begin
         count <= '0;
         tick  <= 1'b0;
      end else if (count == LAST) begin
         count <= '0;
         tick  <= 1'b1;
      end else begin
         count <= count + 1'b1;
         tick  <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  wire          clock,
   input  wire          reset,
   input  wire          rxd,
   input  wire          tick,
   serial_byte_if.rx    link
);

   uart_pkg::rx_state_t state;
   uart_pkg::tick_cnt_t tick_cnt;
   logic [2:0]          bit_cnt;
   uart_pkg::byte_t     rx_shift;

   // two-flop synchronizer, idles high like the line
   logic rxd_meta;
   logic rxd_sync;

   logic done_q;
   logic frame_err_q;

   always_ff @(posedge clock) begin
      if (reset) begin
         rxd_meta <= 1'b1;
         rxd_sync <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state       <= uart_pkg::RX_IDLE;
         tick_cnt    <= '0;
         bit_cnt     <= '0;
         done_q      <= 1'b0;
         frame_err_q <= 1'b0;
      end else begin
         // status outputs are single-cycle pulses
         done_q      <= 1'b0;
         frame_err_q <= 1'b0;
         case (state)
            uart_pkg::RX_IDLE: begin
               // falling edge, start counting towards mid start bit
               if (!rxd_sync) begin
                  tick_cnt <= '0;
                  state    <= uart_pkg::RX_START;
               end
            end
            uart_pkg::RX_START: begin
               if (tick) begin
                  if (tick_cnt == uart_pkg::START_TICKS) begin
                     tick_cnt <= '0;
                     bit_cnt  <= '0;
                     // glitch if line is back high at the centre
                     state    <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            uart_pkg::RX_DATA: begin
               if (tick) begin
                  if (tick_cnt == uart_pkg::BIT_TICKS) begin
                     tick_cnt <= '0;
                     if (bit_cnt == 3'(uart_pkg::DATA_BITS - 1)) begin
                        state <= uart_pkg::RX_STOP;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                     end
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            uart_pkg::RX_STOP: begin
               if (tick) begin
                  if (tick_cnt == uart_pkg::BIT_TICKS) begin
                     tick_cnt    <= '0;
                     state       <= uart_pkg::RX_IDLE;
                     // stop sample decides good byte or framing error
                     done_q      <= rxd_sync;
                     frame_err_q <= !rxd_sync;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            default: state <= uart_pkg::RX_IDLE;
         endcase
      end
   end

   // lsb first, new bit enters at the top
   always_ff @(posedge clock) begin
      if (state == uart_pkg::RX_DATA && tick && tick_cnt == uart_pkg::BIT_TICKS) begin
         rx_shift <= {rxd_sync, rx_shift[uart_pkg::DATA_BITS-1:1]};
      end
   end

   assign link.rx_data      = rx_shift;
   assign link.rx_done      = done_q;
   assign link.rx_frame_err = frame_err_q;

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire          clock,
   input  wire          reset,
   input  wire          tick,
   output logic         txd,
   serial_byte_if.tx    link
);

   uart_pkg::tx_state_t state;
   uart_pkg::tick_cnt_t tick_cnt;
   logic [2:0]          bit_cnt;
   uart_pkg::byte_t     tx_shift;

   // line held high outside a frame
   always_ff @(posedge clock) begin
      if (reset) begin
         state    <= uart_pkg::TX_IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         txd      <= 1'b1;
      end else begin
         case (state)
            uart_pkg::TX_IDLE: begin
               if (link.tx_start) begin
                  tick_cnt <= '0;
                  bit_cnt  <= '0;
                  state    <= uart_pkg::TX_START;
               end
            end
            uart_pkg::TX_START: begin
               if (tick) begin
                  // first tick after the launch opens the start bit
                  txd <= 1'b0;
                  if (tick_cnt == uart_pkg::BIT_TICKS) begin
                     tick_cnt <= '0;
                     state    <= uart_pkg::TX_DATA;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            uart_pkg::TX_DATA: begin
               if (tick) begin
                  txd <= tx_shift[0];
                  if (tick_cnt == uart_pkg::BIT_TICKS) begin
                     tick_cnt <= '0;
                     if (bit_cnt == 3'(uart_pkg::DATA_BITS - 1)) begin
                        state <= uart_pkg::TX_STOP;
                     end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                     end
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            uart_pkg::TX_STOP: begin
               if (tick) begin
                  txd <= 1'b1;
                  // last stop tick frees the transmitter
                  if (tick_cnt == uart_pkg::BIT_TICKS) begin
                     tick_cnt <= '0;
                     state    <= uart_pkg::TX_IDLE;
                  end else begin
                     tick_cnt <= tick_cnt + 1'b1;
                  end
               end
            end
            default: state <= uart_pkg::TX_IDLE;
         endcase
      end
   end

   // load on launch, shift right after each data bit
   always_ff @(posedge clock) begin
      if (state == uart_pkg::TX_IDLE && link.tx_start) begin
         tx_shift <= link.tx_data;
      end else if (state == uart_pkg::TX_DATA && tick && tick_cnt == uart_pkg::BIT_TICKS) begin
         tx_shift <= tx_shift >> 1;
      end
   end

   assign link.tx_busy = (state != uart_pkg::TX_IDLE);

endmodule

`default_nettype wire

//--- link_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module link_ctrl (
   input  wire              clock,
   input  wire              reset,
   input  wire              tx_req,
   output logic             tx_ack,
   input  wire uart_pkg::byte_t tx_data,
   output logic             rx_req,
   input  wire              rx_ack,
   output uart_pkg::byte_t  rx_data,
   output logic             frame_error,
   output logic             overrun,
   serial_byte_if.ctrl      link
);

   uart_pkg::ctrl_state_t rx_state;
   uart_pkg::byte_t       tx_hold;
   uart_pkg::byte_t       rx_buf;
   logic                  tx_start_q;
   logic                  launch;

   // new request, previous ack gone, transmitter free
   assign launch = tx_req && !tx_ack && !link.tx_busy;

   // transmit handshake
   always_ff @(posedge clock) begin
      if (reset) begin
         tx_ack     <= 1'b0;
         tx_start_q <= 1'b0;
      end else begin
         tx_start_q <= launch;
         if (launch) begin
            tx_ack <= 1'b1;
         end else if (tx_ack && !tx_req) begin
            tx_ack <= 1'b0;
         end
      end
   end

   // byte captured while host still holds it
   always_ff @(posedge clock) begin
      if (launch) begin
         tx_hold <= tx_data;
      end
   end

   assign link.tx_data  = tx_hold;
   assign link.tx_start = tx_start_q;

   // receive handshake and sticky flags
   always_ff @(posedge clock) begin
      if (reset) begin
         rx_state    <= uart_pkg::CTRL_IDLE;
         frame_error <= 1'b0;
         overrun     <= 1'b0;
      end else begin
         if (link.rx_frame_err) begin
            frame_error <= 1'b1;
         end
         // byte lands on a busy channel, dropped
         if (link.rx_done && rx_state != uart_pkg::CTRL_IDLE) begin
            overrun <= 1'b1;
         end
         case (rx_state)
            uart_pkg::CTRL_IDLE: begin
               if (link.rx_done) begin
                  rx_state <= uart_pkg::CTRL_OFFER;
               end
            end
            uart_pkg::CTRL_OFFER: begin
               if (rx_ack) begin
                  rx_state <= uart_pkg::CTRL_RELEASE;
               end
            end
            uart_pkg::CTRL_RELEASE: begin
               // wait for host to drop ack
               if (!rx_ack) begin
                  rx_state <= uart_pkg::CTRL_IDLE;
               end
            end
            default: rx_state <= uart_pkg::CTRL_IDLE;
         endcase
      end
   end

   // buffer only loads when the channel is free
   always_ff @(posedge clock) begin
      if (link.rx_done && rx_state == uart_pkg::CTRL_IDLE) begin
         rx_buf <= link.rx_data;
      end
   end

   assign rx_req  = (rx_state == uart_pkg::CTRL_OFFER);
   assign rx_data = rx_buf;

endmodule

`default_nettype wire

//--- uart_link.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link #(
   parameter int CLKS_PER_TICK = 4
) (
   input  wire                  clock,
   input  wire                  reset,
   // serial line
   input  wire                  rxd,
   output wire                  txd,
   // host transmit channel
   input  wire                  tx_req,
   output wire                  tx_ack,
   input  wire uart_pkg::byte_t tx_data,
   // host receive channel
   output wire                  rx_req,
   input  wire                  rx_ack,
   output uart_pkg::byte_t      rx_data,
   // sticky status
   output wire                  frame_error,
   output wire                  overrun
);

   // shared 16x oversampling tick
   wire tick;

   serial_byte_if link_bus ();

   baud_gen #(
      .CLKS_PER_TICK (CLKS_PER_TICK)
   ) i_baud_gen (
      .clock (clock),
      .reset (reset),
      .tick  (tick)
   );

   uart_rx i_uart_rx (
      .clock (clock),
      .reset (reset),
      .rxd   (rxd),
      .tick  (tick),
      .link  (link_bus.rx)
   );

   uart_tx i_uart_tx (
      .clock (clock),
      .reset (reset),
      .tick  (tick),
      .txd   (txd),
      .link  (link_bus.tx)
   );

   link_ctrl i_link_ctrl (
      .clock       (clock),
      .reset       (reset),
      .tx_req      (tx_req),
      .tx_ack      (tx_ack),
      .tx_data     (tx_data),
      .rx_req      (rx_req),
      .rx_ack      (rx_ack),
      .rx_data     (rx_data),
      .frame_error (frame_error),
      .overrun     (overrun),
      .link        (link_bus.ctrl)
   );

endmodule

`default_nettype wire

//--- uart_link_props.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link_props (
   input wire                  clock,
   input wire                  reset,
   input wire                  tx_req,
   input wire                  tx_ack,
   input wire                  rx_req,
   input wire                  rx_ack,
   input wire uart_pkg::byte_t rx_data
);

   // running count of failed properties
   int failures = 0;

   // ack only answers a pending request
   ack_needs_req: assert property (@(posedge clock) disable iff (reset)
      $rose(tx_ack) |-> $past(tx_req))
      else begin
         failures++;
         $error("tx_ack rose without tx_req");
      end

   // ack released only once the host has dropped req
   ack_release: assert property (@(posedge clock) disable iff (reset)
      $fell(tx_ack) |-> !$past(tx_req))
      else begin
         failures++;
         $error("tx_ack fell while tx_req was still high");
      end

   // offer withdrawn only after the host took it
   req_after_ack: assert property (@(posedge clock) disable iff (reset)
      $fell(rx_req) |-> $past(rx_ack))
      else begin
         failures++;
         $error("rx_req fell without rx_ack");
      end

   // offered byte held steady
   data_stable: assert property (@(posedge clock) disable iff (reset)
      (rx_req && $past(rx_req)) |-> $stable(rx_data))
      else begin
         failures++;
         $error("rx_data changed while rx_req was high");
      end

endmodule

bind link_ctrl uart_link_props i_link_props (
   .clock   (clock),
   .reset   (reset),
   .tx_req  (tx_req),
   .tx_ack  (tx_ack),
   .rx_req  (rx_req),
   .rx_ack  (rx_ack),
   .rx_data (rx_data)
);

`default_nettype wire

//--- uart_link_checker.sv
`timescale 1ns/1ps
`default_nettype none

module uart_link_checker (
   input wire                  clock,
   input wire                  reset,
   input wire                  txd,
   input wire                  tx_ack,
   input wire                  rx_req,
   input wire uart_pkg::byte_t rx_data,
   input wire                  frame_error,
   input wire                  overrun
);

   localparam int BIT_CLKS = 64;

   // model, bytes in the order they must show up
   uart_pkg::byte_t rx_expect [$];
   uart_pkg::byte_t tx_expect [$];

   int rx_pending  = 0;
   int tx_pending  = 0;
   int check_count = 0;
   int error_count = 0;
   int test_checks = 0;
   int test_errors = 0;

   logic txd_last;
   logic rx_req_last;

   task automatic expect_rx(input uart_pkg::byte_t data);
      rx_expect.push_back(data);
      rx_pending++;
   endtask

   task automatic expect_tx(input uart_pkg::byte_t data);
      tx_expect.push_back(data);
      tx_pending++;
   endtask

   task automatic compare(input string what, input logic [7:0] got, input logic [7:0] exp);
      check_count++;
      test_checks++;
      if (got !== exp) begin
         error_count++;
         test_errors++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   // byte arrived with nothing left in the model
   task automatic flag_unexpected(input string what, input logic [7:0] got);
      check_count++;
      test_checks++;
      error_count++;
      test_errors++;
      $display("MISMATCH at %0t: unexpected %s %h", $time, what, got);
   endtask

   task automatic check_reset_state();
      compare("txd after reset", txd, 1'b1);
      compare("tx_ack after reset", tx_ack, 1'b0);
      compare("rx_req after reset", rx_req, 1'b0);
      compare("frame_error after reset", frame_error, 1'b0);
      compare("overrun after reset", overrun, 1'b0);
   endtask

   task automatic check_flags(input logic exp_frame_error, input logic exp_overrun);
      compare("frame_error", frame_error, exp_frame_error);
      compare("overrun", overrun, exp_overrun);
   endtask

   task automatic end_test(input string name);
      if (rx_expect.size() != 0 || tx_expect.size() != 0) begin
         error_count++;
         test_errors++;
         $display("test %s ended with %0d receive and %0d transmit bytes never seen",
                  name, rx_expect.size(), tx_expect.size());
      end
      $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   // rising rx_req, byte offered to the host
   always @(posedge clock) begin
      if (reset) begin
         rx_req_last = 1'b0;
      end else begin
         if (rx_req && !rx_req_last) begin
            if (rx_expect.size() == 0) begin
               flag_unexpected("rx byte", rx_data);
            end else begin
               compare("rx byte", rx_data, rx_expect.pop_front());
               rx_pending--;
            end
         end
         rx_req_last = rx_req;
      end
   end

   // called one clock after the falling edge, samples at bit centres
   task automatic decode_tx_frame();
      uart_pkg::byte_t got;
      logic            start_bit;
      logic            stop_bit;
      int              i;
      repeat (BIT_CLKS / 2 - 1) @(posedge clock);
      start_bit = txd;
      for (i = 0; i < 8; i++) begin
         repeat (BIT_CLKS) @(posedge clock);
         got[i] = txd;
      end
      repeat (BIT_CLKS) @(posedge clock);
      stop_bit = txd;
      compare("txd start bit", start_bit, 1'b0);
      compare("txd stop bit", stop_bit, 1'b1);
      if (tx_expect.size() == 0) begin
         flag_unexpected("txd byte", got);
      end else begin
         compare("txd byte", got, tx_expect.pop_front());
         tx_pending--;
      end
   endtask

   // line watcher for txd frames
   initial begin
      txd_last = 1'b1;
      forever begin
         @(posedge clock);
         if (!reset && txd_last === 1'b1 && txd === 1'b0) begin
            decode_tx_frame();
         end
         txd_last = txd;
      end
   end

endmodule

`default_nettype wire

//--- tb_uart_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_link;

   localparam int CLKS_PER_TICK  = 4;
   localparam int BIT_CLKS       = 64;
   localparam int FRAME_CLKS     = 640;
   // 60 frames of traffic, twice over for gaps and handshakes
   localparam int TIMEOUT_CYCLES = 60 * FRAME_CLKS * 2;
   localparam int BURST          = 20;
   localparam int DUPLEX         = 8;

   logic            clock;
   logic            reset;
   logic            rxd;
   logic            tx_req;
   logic            rx_ack;
   uart_pkg::byte_t tx_data;

   wire                  txd;
   wire                  tx_ack;
   wire                  rx_req;
   wire uart_pkg::byte_t rx_data;
   wire                  frame_error;
   wire                  overrun;

   integer seed     = 36;
   logic   hold_ack;
   int     cycle_count;
   int     total_errors;

   uart_link #(
      .CLKS_PER_TICK (CLKS_PER_TICK)
   ) i_uart_link (
      .clock       (clock),
      .reset       (reset),
      .rxd         (rxd),
      .txd         (txd),
      .tx_req      (tx_req),
      .tx_ack      (tx_ack),
      .tx_data     (tx_data),
      .rx_req      (rx_req),
      .rx_ack      (rx_ack),
      .rx_data     (rx_data),
      .frame_error (frame_error),
      .overrun     (overrun)
   );

   uart_link_checker i_checker (
      .clock       (clock),
      .reset       (reset),
      .txd         (txd),
      .tx_ack      (tx_ack),
      .rx_req      (rx_req),
      .rx_data     (rx_data),
      .frame_error (frame_error),
      .overrun     (overrun)
   );

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   function automatic uart_pkg::byte_t random_byte();
      return uart_pkg::byte_t'($random(seed));
   endfunction

   // idle line between frames, long enough for a glitch restart to settle
   function automatic int random_gap();
      return 16 + {$random(seed)} % 64;
   endfunction

   // 8N1 frame on rxd, entered and left on a falling edge
   task automatic send_frame(input uart_pkg::byte_t data, input logic stop_bit);
      int i;
      rxd = 1'b0;
      repeat (BIT_CLKS) @(negedge clock);
      for (i = 0; i < 8; i++) begin
         rxd = data[i];
         repeat (BIT_CLKS) @(negedge clock);
      end
      rxd = stop_bit;
      if (stop_bit) begin
         repeat (BIT_CLKS) @(negedge clock);
      end else begin
         // bad stop only past its centre, receiver restart then sees a glitch
         repeat (BIT_CLKS * 3 / 4) @(negedge clock);
         rxd = 1'b1;
         repeat (BIT_CLKS / 4) @(negedge clock);
      end
   endtask

   // four-phase transmit handshake
   task automatic send_tx(input uart_pkg::byte_t data);
      i_checker.expect_tx(data);
      tx_data = data;
      tx_req  = 1'b1;
      do @(negedge clock); while (!tx_ack);
      tx_req = 1'b0;
      do @(negedge clock); while (tx_ack);
   endtask

   task automatic receive_burst(input int count);
      uart_pkg::byte_t data;
      int              i;
      for (i = 0; i < count; i++) begin
         data = random_byte();
         repeat (random_gap()) @(negedge clock);
         i_checker.expect_rx(data);
         send_frame(data, 1'b1);
      end
   endtask

   task automatic transmit_burst(input int count);
      int i;
      for (i = 0; i < count; i++) begin
         send_tx(random_byte());
      end
   endtask

   // both directions at once, values drawn up front
   task automatic run_duplex(input int count);
      uart_pkg::byte_t rx_bytes [$];
      uart_pkg::byte_t tx_bytes [$];
      int              gaps [$];
      int              i;
      int              j;
      int              k;
      for (i = 0; i < count; i++) begin
         rx_bytes.push_back(random_byte());
         tx_bytes.push_back(random_byte());
         gaps.push_back(random_gap());
      end
      fork
         begin
            for (j = 0; j < count; j++) begin
               repeat (gaps[j]) @(negedge clock);
               i_checker.expect_rx(rx_bytes[j]);
               send_frame(rx_bytes[j], 1'b1);
            end
         end
         begin
            for (k = 0; k < count; k++) begin
               send_tx(tx_bytes[k]);
            end
         end
      join
   endtask

   // all expected bytes seen and receive channel idle
   task automatic wait_drained();
      wait (i_checker.rx_pending == 0 && i_checker.tx_pending == 0);
      @(negedge clock);
      while (rx_req || rx_ack) @(negedge clock);
      @(negedge clock);
   endtask

   // host side of the receive channel
   initial begin
      int delay;
      rx_ack = 1'b0;
      forever begin
         @(negedge clock);
         if (rx_req && !hold_ack) begin
            delay = {$random(seed)} % 8;
            repeat (delay) @(negedge clock);
            rx_ack = 1'b1;
            while (rx_req) @(negedge clock);
            rx_ack = 1'b0;
         end
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clock);
         cycle_count++;
      end
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
   end

   initial begin
      rxd      = 1'b1;
      tx_req   = 1'b0;
      tx_data  = '0;
      hold_ack = 1'b0;
      reset    = 1'b1;
      repeat (3) @(negedge clock);
      reset = 1'b0;
      @(negedge clock);
      i_checker.check_reset_state();
      i_checker.end_test("reset state");

      receive_burst(BURST);
      wait_drained();
      i_checker.check_flags(1'b0, 1'b0);
      i_checker.end_test("receive path");

      transmit_burst(BURST);
      wait_drained();
      i_checker.check_flags(1'b0, 1'b0);
      i_checker.end_test("transmit path");

      // bad frame, then a good one must still get through
      send_frame(random_byte(), 1'b0);
      repeat (random_gap()) @(negedge clock);
      i_checker.check_flags(1'b1, 1'b0);
      receive_burst(1);
      wait_drained();
      i_checker.check_flags(1'b1, 1'b0);
      i_checker.end_test("framing error");

      // second byte lands while the first is still offered
      hold_ack = 1'b1;
      receive_burst(1);
      repeat (random_gap()) @(negedge clock);
      send_frame(random_byte(), 1'b1);
      repeat (16) @(negedge clock);
      i_checker.check_flags(1'b1, 1'b1);
      hold_ack = 1'b0;
      wait_drained();
      repeat (FRAME_CLKS) @(negedge clock);
      i_checker.end_test("overrun");

      run_duplex(DUPLEX);
      wait_drained();
      i_checker.check_flags(1'b1, 1'b1);
      i_checker.end_test("full duplex");

      total_errors = i_checker.error_count + i_uart_link.i_link_ctrl.i_link_props.failures;
      $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
               i_checker.check_count, i_checker.error_count,
               i_uart_link.i_link_ctrl.i_link_props.failures);
      if (total_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
uart_pkg.sv
serial_byte_if.sv
baud_gen.sv
uart_rx.sv
uart_tx.sv
link_ctrl.sv
uart_link.sv
uart_link_props.sv
uart_link_checker.sv
tb_uart_link.sv
